//--- logic/basicTypesPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// common data path and tag types for the
// integer multiply unit, referenced by scope
// from every RTL file that needs them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package basicTypesPkg;

    // one integer register word
    localparam int DATA_WIDTH = 32;

    // operand or result word
    typedef logic [DATA_WIDTH-1:0] DataPath;

    // destination register index, 32 architectural registers
    localparam int TAG_WIDTH = 5;

    // tag travels with each op so writeback can match it
    typedef logic [TAG_WIDTH-1:0] MulTag;

endpackage : basicTypesPkg

`default_nettype wire

//--- logic/mulOpTypesPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiply op codes and the double-width
// product word, seen whole or as two halves
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mulOpTypesPkg;

    // low two bits of funct3 for the M-extension multiplies
    // MUL=000, MULH=001, MULHSU=010, MULHU=011
    typedef enum logic [1:0] {
        MUL_LOW     = 2'b00,
        MUL_HIGH    = 2'b01,
        MUL_HIGH_SU = 2'b10,
        MUL_HIGH_UU = 2'b11
    } IntMulCode;

    // upper and lower word of a product
    typedef struct packed {
        basicTypesPkg::DataPath hi;
        basicTypesPkg::DataPath lo;
    } MulHalves;

    // same 64 bits, two readings
    // core writes full, unit picks from halves
    typedef union packed {
        logic [2*basicTypesPkg::DATA_WIDTH-1:0] full;
        MulHalves                               halves;
    } MulProduct;

endpackage : mulOpTypesPkg

`default_nettype wire

//--- logic/pipelinedMultiplier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipelined 33x33 signed multiplier core
// operands widened by per-operand sign flags,
// product ready PIPELINE_DEPTH unstalled cycles later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module pipelinedMultiplier #(
    parameter int PIPELINE_DEPTH = 3
) (
    input  logic                     clk,
    input  logic                     stall,
    input  basicTypesPkg::DataPath   srcA,
    input  basicTypesPkg::DataPath   srcB,
    input  logic                     signA,
    input  logic                     signB,
    output mulOpTypesPkg::MulProduct dst
);

    localparam int WORD = basicTypesPkg::DATA_WIDTH;

    // 33-bit operands, top bit is sign or zero
    logic signed [WORD:0] extA;
    logic signed [WORD:0] extB;

    // full signed product of two 33-bit values
    logic signed [2*WORD+1:0] fullProduct;

    // product register chain
    logic [2*WORD-1:0] prodStage [PIPELINE_DEPTH];

    // at least one stage for the multiply, one for the output
    generate
        if (PIPELINE_DEPTH < 2) begin : gDepthCheck
            $error("pipelinedMultiplier needs PIPELINE_DEPTH >= 2, got %0d",
                   PIPELINE_DEPTH);
        end
    endgenerate

    // widen each operand
    // signed op copies the msb, unsigned op pads a zero
    always_comb begin
        extA = {signA & srcA[WORD-1], srcA};
        extB = {signB & srcB[WORD-1], srcB};
    end

    // one signed multiply covers all four sign combinations
    always_comb begin
        fullProduct = extA * extB;
    end

    // shift the product along, whole chain frozen by stall
    // low 64 bits are exact for every signedness mix
    always_ff @(posedge clk) begin
        if (!stall) begin
            prodStage[0] <= fullProduct[2*WORD-1:0];
            for (int i = 1; i < PIPELINE_DEPTH; i++) begin
                prodStage[i] <= prodStage[i-1];
            end
        end
    end

    // last stage drives the full-vector view
    always_comb begin
        dst.full = prodStage[PIPELINE_DEPTH-1];
    end

endmodule : pipelinedMultiplier

`default_nettype wire

//--- logic/pipelinedMultiplierUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiply unit around the pipelined core
// decodes signedness, carries valid/tag/half
// select alongside, returns the chosen word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module pipelinedMultiplierUnit #(
    parameter int PIPELINE_DEPTH = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     inValid,
    input  basicTypesPkg::DataPath   opA,
    input  basicTypesPkg::DataPath   opB,
    input  mulOpTypesPkg::IntMulCode mulCode,
    input  basicTypesPkg::MulTag     tag,
    output logic                     outValid,
    output basicTypesPkg::DataPath   dataOut,
    output basicTypesPkg::MulTag     outTag
);

    // operand signedness for the core
    logic signA;
    logic signB;

    // high word wanted, i.e. anything but plain MUL
    logic getUpper;

    // control pipe, one entry per core stage
    logic [PIPELINE_DEPTH-1:0] validPipe;
    logic [PIPELINE_DEPTH-1:0] upperPipe;
    basicTypesPkg::MulTag      tagPipe [PIPELINE_DEPTH];

    // product from the core
    mulOpTypesPkg::MulProduct product;

    pipelinedMultiplier #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) pipelinedMultiplier_inst (
        .clk  (clk),
        .stall(stall),
        .srcA (opA),
        .srcB (opB),
        .signA(signA),
        .signB(signB),
        .dst  (product)
    );

    // decode op code
    // MULHU: both unsigned
    // MULHSU: A signed, B unsigned
    // MUL, MULH: both signed
    always_comb begin
        signA    = (mulCode != mulOpTypesPkg::MUL_HIGH_UU);
        signB    = (mulCode == mulOpTypesPkg::MUL_LOW) ||
                   (mulCode == mulOpTypesPkg::MUL_HIGH);
        getUpper = (mulCode != mulOpTypesPkg::MUL_LOW);
    end

    // valid bits, cleared on reset, held on stall
    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
        end else if (!stall) begin
            validPipe <= {validPipe[PIPELINE_DEPTH-2:0], inValid};
        end
    end

    // half select and tag follow the op, no reset needed
    always_ff @(posedge clk) begin
        if (!stall) begin
            upperPipe  <= {upperPipe[PIPELINE_DEPTH-2:0], getUpper};
            tagPipe[0] <= tag;
            for (int i = 1; i < PIPELINE_DEPTH; i++) begin
                tagPipe[i] <= tagPipe[i-1];
            end
        end
    end

    // last control stage lines up with the core output
    always_comb begin
        outValid = validPipe[PIPELINE_DEPTH-1];
        outTag   = tagPipe[PIPELINE_DEPTH-1];
    end

    // pick hi or lo through the halves view
    always_comb begin
        if (upperPipe[PIPELINE_DEPTH-1]) begin
            dataOut = product.halves.hi;
        end else begin
            dataOut = product.halves.lo;
        end
    end

    // an op may only enter the input stage on an unstalled edge
    // a rise after a stalled cycle means the core issued while stalled
    inValidNoRiseInStall: assert property (
        @(posedge clk) disable iff (reset)
        $rose(inValid) |-> !$past(stall)
    ) else $error("inValid rose after a stalled cycle");

    // control state fully known once out of reset
    outValidKnown: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(outValid)
    ) else $error("outValid is unknown after reset");

endmodule : pipelinedMultiplierUnit

`default_nettype wire

//--- logic/multiplierTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiply unit top level
// registers the issue port once, then feeds
// the pipelined unit; sets pipeline depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module multiplierTop #(
    parameter int PIPELINE_DEPTH = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue,
    input  logic                     stall,
    input  basicTypesPkg::DataPath   opA,
    input  basicTypesPkg::DataPath   opB,
    input  mulOpTypesPkg::IntMulCode mulCode,
    input  basicTypesPkg::MulTag     tag,
    output logic                     resultValid,
    output basicTypesPkg::DataPath   result,
    output basicTypesPkg::MulTag     resultTag
);

    // issue stage, cuts the path from the core's issue logic
    logic                     issueValid;
    basicTypesPkg::DataPath   issueOpA;
    basicTypesPkg::DataPath   issueOpB;
    mulOpTypesPkg::IntMulCode issueCode;
    basicTypesPkg::MulTag     issueTag;

    // valid cleared on reset, frozen with the rest of the pipe
    always_ff @(posedge clk) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else if (!stall) begin
            issueValid <= issue;
        end
    end

    // payload just follows when unstalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            issueOpA  <= opA;
            issueOpB  <= opB;
            issueCode <= mulCode;
            issueTag  <= tag;
        end
    end

    // adds PIPELINE_DEPTH more cycles
    pipelinedMultiplierUnit #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) pipelinedMultiplierUnit_inst (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .inValid (issueValid),
        .opA     (issueOpA),
        .opB     (issueOpB),
        .mulCode (issueCode),
        .tag     (issueTag),
        .outValid(resultValid),
        .dataOut (result),
        .outTag  (resultTag)
    );

endmodule : multiplierTop

`default_nettype wire

//--- tests/multiplierTopTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the multiply unit top level
// directed corner ops, then seeded random issue
// and stall traffic checked against a queue model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module multiplierTopTb;

    localparam int W              = basicTypesPkg::DATA_WIDTH;
    localparam int PIPELINE_DEPTH = 3;
    localparam int CLK_HALF       = 20;
    localparam int RESET_CYCLES   = 8;
    // 4 codes x 4 corner A x 4 corner B
    localparam int DIRECTED_OPS   = 64;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int DRAIN_MARGIN   = 200;
    localparam int CYCLE_LIMIT    = RESET_CYCLES + DIRECTED_OPS + RANDOM_CYCLES + DRAIN_MARGIN;
    localparam logic [31:0] RANDOM_SEED = 32'h42f00080;

    logic                     clk;
    logic                     reset;
    logic                     issue;
    logic                     stall;
    basicTypesPkg::DataPath   opA;
    basicTypesPkg::DataPath   opB;
    mulOpTypesPkg::IntMulCode mulCode;
    basicTypesPkg::MulTag     tag;
    logic                     resultValid;
    basicTypesPkg::DataPath   result;
    basicTypesPkg::MulTag     resultTag;

    // expected results in issue order
    basicTypesPkg::DataPath wordQ [$];
    basicTypesPkg::MulTag   tagQ [$];

    int mismatchCount;
    int otherErrors;
    int issuedCount;
    int receivedCount;
    int cycleCount;

    multiplierTop #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) multiplierTop_inst (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .stall      (stall),
        .opA        (opA),
        .opB        (opB),
        .mulCode    (mulCode),
        .tag        (tag),
        .resultValid(resultValid),
        .result     (result),
        .resultTag  (resultTag)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // reference model, each operand widened to 64 bits by the op's own rule
    // low 64 bits of that product are exact, then take the half asked for
    function automatic basicTypesPkg::DataPath expectedWord(
        input mulOpTypesPkg::IntMulCode code,
        input basicTypesPkg::DataPath   a,
        input basicTypesPkg::DataPath   b
    );
        logic           aSigned;
        logic           bSigned;
        logic [2*W-1:0] wideA;
        logic [2*W-1:0] wideB;
        logic [2*W-1:0] prod;
        case (code)
            mulOpTypesPkg::MUL_HIGH: begin
                // MULH, signed times signed
                aSigned = 1'b1;
                bSigned = 1'b1;
            end
            mulOpTypesPkg::MUL_HIGH_SU: begin
                // MULHSU, signed times unsigned
                aSigned = 1'b1;
                bSigned = 1'b0;
            end
            default: begin
                // MULHU, and MUL whose low word does not depend on signedness
                aSigned = 1'b0;
                bSigned = 1'b0;
            end
        endcase
        wideA = aSigned ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
        wideB = bSigned ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
        prod  = wideA * wideB;
        if (code == mulOpTypesPkg::MUL_LOW) begin
            return prod[W-1:0];
        end else begin
            return prod[2*W-1:W];
        end
    endfunction

    // corner operands zero, one, all ones and most negative
    function automatic basicTypesPkg::DataPath cornerValue(input int idx);
        case (idx)
            0:       return '0;
            1:       return 1;
            2:       return '1;
            default: return {1'b1, {(W-1){1'b0}}};
        endcase
    endfunction

    // a quarter of the draws land on a corner
    function automatic basicTypesPkg::DataPath randomOperand();
        int pick;
        pick = $urandom % 16;
        if (pick < 4) begin
            return cornerValue(pick);
        end else begin
            return $urandom;
        end
    endfunction

    function automatic void printCounts();
        $display("errors: %0d mismatches, %0d other failures (%0d issued, %0d returned)",
                 mismatchCount, otherErrors, issuedCount, receivedCount);
    endfunction

    // model and checker, samples pre-edge values
    always @(posedge clk) begin
        basicTypesPkg::DataPath expWord;
        basicTypesPkg::MulTag   expTag;
        if (!reset) begin
            // nothing pending means resultValid is a clean low
            if (wordQ.size() == 0) begin
                assert (resultValid === 1'b0) else begin
                    otherErrors++;
                    $display("unexpected result: resultValid is %b with no op pending, tag %h",
                             resultValid, resultTag);
                end
            end
            // every unstalled result counts, pending or not
            if (resultValid === 1'b1 && !stall) begin
                receivedCount++;
                if (wordQ.size() != 0) begin
                    expWord = wordQ.pop_front();
                    expTag  = tagQ.pop_front();
                    assert (result === expWord) else begin
                        mismatchCount++;
                        $display("mismatch result: expected %h, actual %h", expWord, result);
                    end
                    assert (resultTag === expTag) else begin
                        mismatchCount++;
                        $display("mismatch resultTag: expected %h, actual %h",
                                 expTag, resultTag);
                    end
                end
            end
            // accepted issue, queue the reference answer
            if (issue && !stall) begin
                wordQ.push_back(expectedWord(mulCode, opA, opB));
                tagQ.push_back(tag);
                issuedCount++;
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles, %0d ops still pending",
                     CYCLE_LIMIT, wordQ.size());
            printCounts();
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // stimulus
    initial begin
        logic stallNext;
        logic issueNext;
        int   opCount;
        reset         = 1'b1;
        issue         = 1'b0;
        stall         = 1'b0;
        opA           = '0;
        opB           = '0;
        mulCode       = mulOpTypesPkg::MUL_LOW;
        tag           = '0;
        mismatchCount = 0;
        otherErrors   = 0;
        issuedCount   = 0;
        receivedCount = 0;
        cycleCount    = 0;
        opCount       = 0;
        void'($urandom(RANDOM_SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // every code over every corner pair, back to back
        for (int ci = 0; ci < 4; ci++) begin
            for (int ai = 0; ai < 4; ai++) begin
                for (int bi = 0; bi < 4; bi++) begin
                    @(posedge clk);
                    issue   <= 1'b1;
                    stall   <= 1'b0;
                    opA     <= cornerValue(ai);
                    opB     <= cornerValue(bi);
                    mulCode <= mulOpTypesPkg::IntMulCode'(ci);
                    tag     <= basicTypesPkg::MulTag'(opCount);
                    opCount++;
                end
            end
        end

        // random traffic, issue held low whenever stall is up
        for (int cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
            @(posedge clk);
            stallNext = (($urandom % 8) == 0);
            issueNext = !stallNext && (($urandom % 2) == 1);
            stall   <= stallNext;
            issue   <= issueNext;
            opA     <= randomOperand();
            opB     <= randomOperand();
            mulCode <= mulOpTypesPkg::IntMulCode'($urandom % 4);
            tag     <= basicTypesPkg::MulTag'($urandom);
        end

        // drain
        @(posedge clk);
        issue <= 1'b0;
        stall <= 1'b0;
        while (wordQ.size() != 0) begin
            @(posedge clk);
        end
        // idle tail, any valid here is a phantom
        repeat (2 * PIPELINE_DEPTH + 4) @(posedge clk);

        assert (wordQ.size() == 0) else begin
            otherErrors++;
            $display("missing results: %0d ops never returned", wordQ.size());
        end
        assert (receivedCount == issuedCount) else begin
            otherErrors++;
            $display("result count differs from issue count: %0d issued, %0d returned",
                     issuedCount, receivedCount);
        end

        printCounts();
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : multiplierTopTb

`default_nettype wire

//--- sim.f
logic/basicTypesPkg.sv
logic/mulOpTypesPkg.sv
logic/pipelinedMultiplier.sv
logic/pipelinedMultiplierUnit.sv
logic/multiplierTop.sv
tests/multiplierTopTb.sv
